//--- verilog/fractal_sync_defs.svh
`ifndef FRACTAL_SYNC_DEFS_SVH
`define FRACTAL_SYNC_DEFS_SVH

// Request ports on one remote register file
`define FS_N_PORTS 4

// Level encoding where value 0 stands for level 1
`define FS_LEVEL_WIDTH 2

// Barrier id and its local part without the lowest bit
`define FS_ID_WIDTH       3
`define FS_LOCAL_ID_WIDTH 2
`define FS_N_LOCAL_IDS    4

// Back-routing source/destination mask
`define FS_SD_WIDTH 2
`define FS_SD_BOTH  {`FS_SD_WIDTH{1'b1}}

// Directly mapped store geometry
`define FS_N_DM_REGS 10
`define FS_SIG_WIDTH 4
`define FS_MAX_SIG   9

// Unchecked base plus local id needs one more bit
`define FS_RAW_SIG_WIDTH 5

`endif

//--- verilog/fractal_sync_pkg.sv
`include "fractal_sync_defs.svh"

package fractal_sync_pkg;

  // Request fields
  typedef logic [`FS_LEVEL_WIDTH-1:0]    level_t;     // Synchronization level
  typedef logic [`FS_ID_WIDTH-1:0]       id_t;        // Full barrier id
  typedef logic [`FS_LOCAL_ID_WIDTH-1:0] local_id_t;  // Id without lowest bit

  // Back-routing mask
  typedef logic [`FS_SD_WIDTH-1:0] sd_t;

  // Register index into the store
  typedef logic [`FS_SIG_WIDTH-1:0] sig_t;

  // Level base plus local id before range check
  typedef logic [`FS_RAW_SIG_WIDTH-1:0] raw_sig_t;

endpackage

//--- verilog/fractal_sync_sig_gen.sv
`timescale 1ns/100ps
`include "fractal_sync_defs.svh"

module fractal_sync_sig_gen (
  input  fractal_sync_pkg::level_t    level_i,      // Level of the request
  input  fractal_sync_pkg::id_t       id_i,         // Barrier id
  input  logic                        check_i,      // Check strobe
  input  logic                        set_i,        // Set strobe
  output fractal_sync_pkg::local_id_t local_id_o,   // Id used for collision search
  output fractal_sync_pkg::sig_t      sig_o,        // Register index
  output logic                        sig_valid_o,  // Index inside level range
  output logic                        sig_err_o     // Bad index on a live request
);

  localparam int unsigned n_lvl_bases = 2**`FS_LEVEL_WIDTH + 1;  // Extra slot for sentinel

  // First register of each level, last entry closes level 4
  localparam fractal_sync_pkg::raw_sig_t lvl_base [n_lvl_bases] = '{
    5'd0,   // Level 1
    5'd1,   // Level 2
    5'd2,   // Level 3
    5'd6,   // Level 4
    5'd10   // Sentinel
  };

  logic [`FS_LEVEL_WIDTH:0]   next_lvl;  // Lookup slot of the level above
  fractal_sync_pkg::raw_sig_t lvl_lo;    // Base of own level
  fractal_sync_pkg::raw_sig_t lvl_hi;    // Base of next level
  fractal_sync_pkg::raw_sig_t raw_sig;   // Unchecked signature

  assign local_id_o = id_i[`FS_ID_WIDTH-1:1];  // Drop the lowest id bit

  assign next_lvl = {1'b0, level_i} + 1'b1;  // Never wraps, one bit wider
  assign lvl_lo   = lvl_base[level_i];
  assign lvl_hi   = lvl_base[next_lvl];

  assign raw_sig = lvl_lo + fractal_sync_pkg::raw_sig_t'(local_id_o);
  assign sig_o   = raw_sig[`FS_SIG_WIDTH-1:0];  // Upper bit is zero when valid

  // In range of the store and not spilling into the next level
  assign sig_valid_o = (raw_sig <= fractal_sync_pkg::raw_sig_t'(`FS_MAX_SIG)) &&
                       (raw_sig < lvl_hi);

  // Only flagged while a strobe is up
  assign sig_err_o = ~sig_valid_o & (check_i | set_i);

endmodule

//--- verilog/fractal_sync_collision_arb.sv
`timescale 1ns/100ps
`include "fractal_sync_defs.svh"

module fractal_sync_collision_arb (
  input  fractal_sync_pkg::local_id_t local_id_i [`FS_N_PORTS],  // Local id per port
  input  fractal_sync_pkg::sd_t       sd_i       [`FS_N_PORTS],  // Incoming back-routing
  input  logic                        check_i    [`FS_N_PORTS],  // Raw check strobes
  input  logic                        set_i      [`FS_N_PORTS],  // Raw set strobes
  output logic                        bypass_o   [`FS_N_PORTS],  // First of a clash
  output logic                        ignore_o   [`FS_N_PORTS],  // Later ones of a clash
  output logic                        check_rf_o [`FS_N_PORTS],  // Check towards store
  output logic                        set_rf_o   [`FS_N_PORTS],  // Set towards store
  output fractal_sync_pkg::sd_t       sd_rf_o    [`FS_N_PORTS]   // Back-routing to store
);

  logic                   pending   [`FS_N_PORTS];     // Any strobe on port
  logic [`FS_N_PORTS-1:0] id_hit    [`FS_N_LOCAL_IDS]; // Pending ports per local id
  logic [`FS_N_PORTS-1:0] id_first  [`FS_N_LOCAL_IDS]; // Lowest pending port
  logic [`FS_N_PORTS-1:0] id_ignore [`FS_N_LOCAL_IDS]; // All pending ports after it
  logic                   id_clash  [`FS_N_LOCAL_IDS]; // More than one port on id

  for (genvar p = 0; p < `FS_N_PORTS; p++) begin : gen_pending
    assign pending[p] = check_i[p] | set_i[p];
  end

  // Per local id view across all ports
  for (genvar l = 0; l < `FS_N_LOCAL_IDS; l++) begin : gen_local_id
    for (genvar p = 0; p < `FS_N_PORTS; p++) begin : gen_hit
      assign id_hit[l][p] = pending[p] &&
                            (local_id_i[p] == fractal_sync_pkg::local_id_t'(l));
    end

    // Two's complement trick keeps only the lowest set bit
    assign id_first[l]  = id_hit[l] & (~id_hit[l] + 1'b1);
    assign id_ignore[l] = id_hit[l] & ~id_first[l];
    assign id_clash[l]  = |id_ignore[l];  // Someone lost the race
  end

  // Fold the per id results back onto each port
  for (genvar p = 0; p < `FS_N_PORTS; p++) begin : gen_port
    always_comb begin
      bypass_o[p] = 1'b0;
      ignore_o[p] = 1'b0;
      for (int l = 0; l < `FS_N_LOCAL_IDS; l++) begin
        bypass_o[p] |= id_first[l][p] & id_clash[l];  // Lone request is no bypass
        ignore_o[p] |= id_ignore[l][p];
      end
    end

    // Clashing requests route back to both sides
    assign sd_rf_o[p] = (bypass_o[p] | ignore_o[p]) ? `FS_SD_BOTH : sd_i[p];

    // Bypassed check is answered locally, ignored port reaches nothing
    assign check_rf_o[p] = check_i[p] & ~(bypass_o[p] | ignore_o[p]);
    assign set_rf_o[p]   = set_i[p] & ~ignore_o[p];  // Bypassed set still lands
  end

endmodule

//--- verilog/fractal_sync_dm_rf.sv
`timescale 1ns/100ps
`include "fractal_sync_defs.svh"

module fractal_sync_dm_rf (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  logic                   check_i     [`FS_N_PORTS],  // Look up and consume
  input  logic                   set_i       [`FS_N_PORTS],  // Arrive at barrier
  input  logic                   idx_valid_i [`FS_N_PORTS],  // Index usable
  input  fractal_sync_pkg::sig_t idx_i       [`FS_N_PORTS],  // Register index
  input  fractal_sync_pkg::sd_t  sd_i        [`FS_N_PORTS],  // Mask to store
  output logic                   present_o   [`FS_N_PORTS],  // Entry was held last cycle
  output fractal_sync_pkg::sd_t  sd_o        [`FS_N_PORTS]   // Stored mask of that entry
);

  // Pending barrier arrivals
  logic                  entry_valid [`FS_N_DM_REGS];
  fractal_sync_pkg::sd_t entry_sd    [`FS_N_DM_REGS];

  logic req   [`FS_N_PORTS];  // Live request with good index
  logic hit   [`FS_N_PORTS];  // Request found a held entry
  logic store [`FS_N_PORTS];  // Set into an empty entry

  // Same signature never shows up twice after collision filtering
  for (genvar p = 0; p < `FS_N_PORTS; p++) begin : gen_port_dec
    assign req[p]   = idx_valid_i[p] & (check_i[p] | set_i[p]);
    assign hit[p]   = req[p] & entry_valid[idx_i[p]];  // Index read only matters with req
    assign store[p] = req[p] & set_i[p] & ~hit[p];     // Set wins over check
  end

  // Entry occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int e = 0; e < `FS_N_DM_REGS; e++) begin
        entry_valid[e] <= 1'b0;  // Start empty
      end
    end else begin
      for (int p = 0; p < `FS_N_PORTS; p++) begin
        if (hit[p]) begin
          entry_valid[idx_i[p]] <= 1'b0;  // Barrier met, free it
        end else if (store[p]) begin
          entry_valid[idx_i[p]] <= 1'b1;  // First arrival waits here
        end
      end
    end
  end

  // Back-routing masks of waiting arrivals
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `FS_N_PORTS; p++) begin
      if (store[p]) begin
        entry_sd[idx_i[p]] <= sd_i[p];
      end
    end
  end

  // One cycle response per port
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int p = 0; p < `FS_N_PORTS; p++) begin
        present_o[p] <= 1'b0;
        sd_o[p]      <= '0;
      end
    end else begin
      for (int p = 0; p < `FS_N_PORTS; p++) begin
        present_o[p] <= hit[p];
        sd_o[p]      <= hit[p] ? entry_sd[idx_i[p]] : '0;  // Zero when nothing found
      end
    end
  end

endmodule

//--- verilog/fractal_sync_remote_rf.sv
`timescale 1ns/100ps
`include "fractal_sync_defs.svh"

module fractal_sync_remote_rf (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  input  fractal_sync_pkg::level_t level_i   [`FS_N_PORTS],  // Level per port
  input  fractal_sync_pkg::id_t    id_i      [`FS_N_PORTS],  // Barrier id per port
  input  fractal_sync_pkg::sd_t    sd_i      [`FS_N_PORTS],  // Back-routing per port
  input  logic                     check_i   [`FS_N_PORTS],  // Check strobes
  input  logic                     set_i     [`FS_N_PORTS],  // Set strobes
  output logic                     present_o [`FS_N_PORTS],  // Registered hit
  output fractal_sync_pkg::sd_t    sd_o      [`FS_N_PORTS],  // Registered stored mask
  output logic                     sig_err_o [`FS_N_PORTS],  // Same cycle bad signature
  output logic                     bypass_o  [`FS_N_PORTS],  // Same cycle clash winner
  output logic                     ignore_o  [`FS_N_PORTS]   // Same cycle clash loser
);

  // Signature generator results
  fractal_sync_pkg::local_id_t local_id  [`FS_N_PORTS];
  fractal_sync_pkg::sig_t      sig       [`FS_N_PORTS];
  logic                        sig_valid [`FS_N_PORTS];

  // Filtered requests into the store
  logic                  check_rf [`FS_N_PORTS];
  logic                  set_rf   [`FS_N_PORTS];
  fractal_sync_pkg::sd_t sd_rf    [`FS_N_PORTS];

  // One signature generator per port
  for (genvar p = 0; p < `FS_N_PORTS; p++) begin : gen_sig
    fractal_sync_sig_gen i_sig_gen (
      .level_i     ( level_i[p]   ),
      .id_i        ( id_i[p]      ),
      .check_i     ( check_i[p]   ),
      .set_i       ( set_i[p]     ),
      .local_id_o  ( local_id[p]  ),
      .sig_o       ( sig[p]       ),
      .sig_valid_o ( sig_valid[p] ),
      .sig_err_o   ( sig_err_o[p] )
    );
  end

  // Same barrier hits across ports in one cycle
  fractal_sync_collision_arb i_collision_arb (
    .local_id_i ( local_id ),
    .sd_i       ( sd_i     ),
    .check_i    ( check_i  ),
    .set_i      ( set_i    ),
    .bypass_o   ( bypass_o ),
    .ignore_o   ( ignore_o ),
    .check_rf_o ( check_rf ),
    .set_rf_o   ( set_rf   ),
    .sd_rf_o    ( sd_rf    )
  );

  // Directly mapped store indexed by signature
  fractal_sync_dm_rf i_dm_rf (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .check_i     ( check_rf  ),
    .set_i       ( set_rf    ),
    .idx_valid_i ( sig_valid ),
    .idx_i       ( sig       ),
    .sd_i        ( sd_rf     ),
    .present_o   ( present_o ),
    .sd_o        ( sd_o      )
  );

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,     // Free running clock
  output logic arst_n_o   // Active low reset
);

  localparam int half_period = 2;  // 4 ns period

  initial begin
    clk_o = 1'b0;
    forever #half_period clk_o = ~clk_o;
  end

  // Reset held over two rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 arst_n_o = 1'b1;  // Release clear of the edge
  end

endmodule

//--- testbench/tb_fractal_sync_remote_rf.sv
`timescale 1ns/100ps
`include "fractal_sync_defs.svh"

module tb_fractal_sync_remote_rf;

  localparam int          n_rows     = 16;            // Table length
  localparam int          clk_period = 4;             // ns
  localparam int unsigned seed       = 32'h79c7fc26;  // Fixed random seed

  logic clk;
  logic arst_n;

  // DUT inputs
  fractal_sync_pkg::level_t level [`FS_N_PORTS];
  fractal_sync_pkg::id_t    id    [`FS_N_PORTS];
  fractal_sync_pkg::sd_t    sd_in [`FS_N_PORTS];
  logic                     check [`FS_N_PORTS];
  logic                     set   [`FS_N_PORTS];

  // DUT outputs
  logic                  present [`FS_N_PORTS];
  fractal_sync_pkg::sd_t sd_out  [`FS_N_PORTS];
  logic                  sig_err [`FS_N_PORTS];
  logic                  bypass  [`FS_N_PORTS];
  logic                  ignore  [`FS_N_PORTS];

  // Stimulus columns
  fractal_sync_pkg::level_t tab_level   [n_rows][`FS_N_PORTS];
  fractal_sync_pkg::id_t    tab_id      [n_rows][`FS_N_PORTS];
  fractal_sync_pkg::sd_t    tab_sd      [n_rows][`FS_N_PORTS];
  logic                     tab_check   [n_rows][`FS_N_PORTS];
  logic                     tab_set     [n_rows][`FS_N_PORTS];
  logic                     tab_rand_sd [n_rows];  // Row outcome blind to sd

  // Expected columns, flags same cycle, response next cycle
  logic                  exp_err     [n_rows][`FS_N_PORTS];
  logic                  exp_bypass  [n_rows][`FS_N_PORTS];
  logic                  exp_ignore  [n_rows][`FS_N_PORTS];
  logic                  exp_present [n_rows][`FS_N_PORTS];
  fractal_sync_pkg::sd_t exp_sd      [n_rows][`FS_N_PORTS];

  int          n_errors;
  int          n_checks;
  int unsigned rnd;

  tb_clk_gen u_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  fractal_sync_remote_rf u_dut (
    .clk_i     ( clk     ),
    .arst_n_i  ( arst_n  ),
    .level_i   ( level   ),
    .id_i      ( id      ),
    .sd_i      ( sd_in   ),
    .check_i   ( check   ),
    .set_i     ( set     ),
    .present_o ( present ),
    .sd_o      ( sd_out  ),
    .sig_err_o ( sig_err ),
    .bypass_o  ( bypass  ),
    .ignore_o  ( ignore  )
  );

  task automatic compare_val(input string name, input int port,
                             input logic [31:0] exp_val, input logic [31:0] act_val);
    n_checks++;
    if (act_val !== exp_val) begin  // Catches X as well
      n_errors++;
      $display("** Error: %s[%0d] expected 0x%0h, got 0x%0h at %0t",
               name, port, exp_val, act_val, $time);
    end
  endtask

  task automatic put_req(input int r, input int p,
                         input fractal_sync_pkg::level_t lvl, input fractal_sync_pkg::id_t bid,
                         input fractal_sync_pkg::sd_t sdv, input logic chk, input logic st);
    tab_level[r][p] = lvl;
    tab_id[r][p]    = bid;
    tab_sd[r][p]    = sdv;
    tab_check[r][p] = chk;
    tab_set[r][p]   = st;
  endtask

  task automatic put_exp(input int r, input int p, input logic err, input logic byp,
                         input logic ign, input logic pres, input fractal_sync_pkg::sd_t sdv);
    exp_err[r][p]     = err;
    exp_bypass[r][p]  = byp;
    exp_ignore[r][p]  = ign;
    exp_present[r][p] = pres;
    exp_sd[r][p]      = sdv;
  endtask

  task automatic load_table();
    for (int r = 0; r < n_rows; r++) begin
      tab_rand_sd[r] = 1'b1;  // Most rows store nothing of their own
      for (int p = 0; p < `FS_N_PORTS; p++) begin
        put_req(r, p, '0, '0, '0, 1'b0, 1'b0);
        put_exp(r, p, 1'b0, 1'b0, 1'b0, 1'b0, '0);
      end
    end
    put_req(0, 0, 2'd0, 3'd2, 2'd0, 1'b0, 1'b0);  // Bad signature but no strobe
    // Level 1 id 2 lands on sig 1, outside level 1
    put_req(1, 0, 2'd0, 3'd2, 2'd0, 1'b0, 1'b1);
    put_exp(1, 0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0);
    put_req(1, 1, 2'd2, 3'd6, 2'd0, 1'b1, 1'b0);  // Sig 5, fine, entry empty
    // Round trip on sig 7
    put_req(2, 0, 2'd3, 3'd2, 2'd1, 1'b0, 1'b1);
    tab_rand_sd[2] = 1'b0;
    put_req(3, 3, 2'd1, 3'd1, 2'd0, 1'b1, 1'b0);  // Bad set of row 1 left sig 1 empty
    put_req(4, 2, 2'd3, 3'd2, 2'd0, 1'b1, 1'b0);
    put_exp(4, 2, 1'b0, 1'b0, 1'b0, 1'b1, 2'd1);
    put_req(5, 2, 2'd3, 3'd2, 2'd0, 1'b1, 1'b0);  // Entry already consumed
    // Two sets meet on sig 4
    put_req(6, 1, 2'd2, 3'd4, 2'd2, 1'b0, 1'b1);
    tab_rand_sd[6] = 1'b0;
    put_req(7, 3, 2'd2, 3'd5, 2'd1, 1'b0, 1'b1);
    put_exp(7, 3, 1'b0, 1'b0, 1'b0, 1'b1, 2'd2);  // First arrival's mask
    tab_rand_sd[7] = 1'b0;
    put_req(8, 0, 2'd2, 3'd4, 2'd0, 1'b1, 1'b0);  // Cleared by the meet
    // Clash on local id 0, port 1 wins, port 3 aims at sig 2
    put_req(9, 1, 2'd3, 3'd0, 2'd1, 1'b0, 1'b1);
    put_req(9, 3, 2'd2, 3'd1, 2'd2, 1'b0, 1'b1);
    put_exp(9, 1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0);
    put_exp(9, 3, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0);
    tab_rand_sd[9] = 1'b0;
    put_req(10, 0, 2'd3, 3'd1, 2'd0, 1'b1, 1'b0);  // Sig 6 holds both sides
    put_exp(10, 0, 1'b0, 1'b0, 1'b0, 1'b1, `FS_SD_BOTH);
    put_req(11, 2, 2'd2, 3'd1, 2'd0, 1'b1, 1'b0);  // Ignored set left sig 2 empty
    // All ports in parallel on sigs 2 to 5
    put_req(12, 0, 2'd2, 3'd0, 2'd1, 1'b0, 1'b1);
    put_req(12, 1, 2'd2, 3'd2, 2'd2, 1'b0, 1'b1);
    put_req(12, 2, 2'd2, 3'd4, 2'd3, 1'b0, 1'b1);
    put_req(12, 3, 2'd2, 3'd6, 2'd1, 1'b0, 1'b1);
    tab_rand_sd[12] = 1'b0;
    put_req(13, 0, 2'd2, 3'd1, 2'd0, 1'b1, 1'b0);  // Odd ids, same local ids
    put_req(13, 1, 2'd2, 3'd3, 2'd0, 1'b1, 1'b0);
    put_req(13, 2, 2'd2, 3'd5, 2'd0, 1'b1, 1'b0);
    put_req(13, 3, 2'd2, 3'd7, 2'd0, 1'b1, 1'b0);
    put_exp(13, 0, 1'b0, 1'b0, 1'b0, 1'b1, 2'd1);
    put_exp(13, 1, 1'b0, 1'b0, 1'b0, 1'b1, 2'd2);
    put_exp(13, 2, 1'b0, 1'b0, 1'b0, 1'b1, 2'd3);
    put_exp(13, 3, 1'b0, 1'b0, 1'b0, 1'b1, 2'd1);
    // Three way clash of checks, nothing reaches the store
    put_req(14, 0, 2'd0, 3'd0, 2'd0, 1'b1, 1'b0);
    put_req(14, 2, 2'd0, 3'd1, 2'd0, 1'b1, 1'b0);
    put_req(14, 3, 2'd0, 3'd0, 2'd0, 1'b1, 1'b0);
    put_exp(14, 0, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0);
    put_exp(14, 2, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0);
    put_exp(14, 3, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0);
  endtask

  task automatic clear_inputs();
    for (int p = 0; p < `FS_N_PORTS; p++) begin
      level[p] = '0;
      id[p]    = '0;
      sd_in[p] = '0;
      check[p] = 1'b0;
      set[p]   = 1'b0;
    end
  endtask

  task automatic apply_row(input int r);
    for (int p = 0; p < `FS_N_PORTS; p++) begin
      level[p] = tab_level[r][p];
      id[p]    = tab_id[r][p];
      check[p] = tab_check[r][p];
      set[p]   = tab_set[r][p];
      if (tab_rand_sd[r]) begin
        rnd      = $urandom;
        sd_in[p] = rnd[`FS_SD_WIDTH-1:0];
      end else begin
        sd_in[p] = tab_sd[r][p];
      end
    end
  endtask

  // Combinational flags of the row now on the inputs
  task automatic inspect_flags(input int r);
    for (int p = 0; p < `FS_N_PORTS; p++) begin
      compare_val("sig_err_o", p, exp_err[r][p], sig_err[p]);
      compare_val("bypass_o", p, exp_bypass[r][p], bypass[p]);
      compare_val("ignore_o", p, exp_ignore[r][p], ignore[p]);
    end
  endtask

  // Registered response to row r, negative row means reset state
  task automatic verify_response(input int r);
    logic                  want_present;
    fractal_sync_pkg::sd_t want_sd;
    for (int p = 0; p < `FS_N_PORTS; p++) begin
      if (r < 0) begin
        want_present = 1'b0;
        want_sd      = '0;
      end else begin
        want_present = exp_present[r][p];
        want_sd      = exp_sd[r][p];
      end
      compare_val("present_o", p, want_present, present[p]);
      compare_val("sd_o", p, want_sd, sd_out[p]);
    end
  endtask

  initial begin
    clear_inputs();
    n_errors = 0;
    n_checks = 0;
    rnd      = $urandom(seed);  // Seed once for the whole run
    load_table();
    wait (arst_n === 1'b1);
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk);
      #1;
      apply_row(r);
      #2;                      // Settled, well before next edge
      inspect_flags(r);
      verify_response(r - 1);  // One cycle latency
    end
    @(posedge clk);
    #1;
    clear_inputs();
    #2;
    verify_response(n_rows - 1);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog, generous margin over the table length
  initial begin
    #(n_rows * clk_period * 4 + 100);
    $display("Timeout: the stimulus table did not complete in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- list.f
+incdir+verilog
verilog/fractal_sync_pkg.sv
verilog/fractal_sync_sig_gen.sv
verilog/fractal_sync_collision_arb.sv
verilog/fractal_sync_dm_rf.sv
verilog/fractal_sync_remote_rf.sv
testbench/tb_clk_gen.sv
testbench/tb_fractal_sync_remote_rf.sv

//--- Bender.yml
package:
  name: fractal_sync

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fractal_sync_pkg.sv
      - verilog/fractal_sync_sig_gen.sv
      - verilog/fractal_sync_collision_arb.sv
      - verilog/fractal_sync_dm_rf.sv
      - verilog/fractal_sync_remote_rf.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_fractal_sync_remote_rf.sv
